//--- hw/pixelOutput.sv
`default_nettype none

module pixelOutput (
	input wire logic clk,
	input wire logic reset,
	input wire logic active,
	input wire logic hSyncRaw,
	input wire logic vSyncRaw,
	input wire vgaPkg::color_t imageColor,
	input wire vgaPkg::color_t tileColor,
	input wire logic ingame,
	output logic hSync,
	output logic vSync,
	output logic [vgaPkg::CHANNEL_BITS-1:0] vgaR,
	output logic [vgaPkg::CHANNEL_BITS-1:0] vgaG,
	output logic [vgaPkg::CHANNEL_BITS-1:0] vgaB
);

	import vgaPkg::*;

	// Two stage delay lines for the raster controls
	// Bit 0 is one cycle behind the timing generator, bit 1 two cycles
	logic [1:0] activeDelay;
	logic [1:0] hSyncDelay;
	logic [1:0] vSyncDelay;

	// Final registered color
	color_t colorOut;
	color_t colorNext;

	// Control delay, cleared to blank and sync inactive
	always_ff @(posedge clk) begin
		if (reset) begin
			activeDelay <= '0;
			hSyncDelay <= '1;
			vSyncDelay <= '1;
		end else begin
			activeDelay <= {activeDelay[0], active};
			hSyncDelay <= {hSyncDelay[0], hSyncRaw};
			vSyncDelay <= {vSyncDelay[0], vSyncRaw};
		end
	end

	// Picture select
	// Score board while the game runs, attract image otherwise
	always_comb begin
		if (!activeDelay[1]) begin
			colorNext = COLOR_BLACK;
		end else if (ingame) begin
			colorNext = tileColor;
		end else begin
			colorNext = imageColor;
		end
	end

	// Output register, ingame is sampled here
	always_ff @(posedge clk) begin
		if (reset) begin
			hSync <= 1'b1;
			vSync <= 1'b1;
			colorOut <= COLOR_BLACK;
		end else begin
			hSync <= hSyncDelay[1];
			vSync <= vSyncDelay[1];
			colorOut <= colorNext;
		end
	end

	// Split into the three channels, red on top
	assign vgaR = colorOut[3*CHANNEL_BITS-1:2*CHANNEL_BITS];
	assign vgaG = colorOut[2*CHANNEL_BITS-1:CHANNEL_BITS];
	assign vgaB = colorOut[CHANNEL_BITS-1:0];

endmodule

`default_nettype wire

//--- hw/scoreTiles.sv
`default_nettype none

module scoreTiles #(
	parameter int WIDTH = 640,
	parameter int HEIGHT = 480
) (
	input wire logic clk,
	input wire logic [$clog2(WIDTH)-1:0] x,
	input wire logic [$clog2(HEIGHT)-1:0] y,
	input wire vgaPkg::score_t score,
	output vgaPkg::color_t tileColor
);

	import vgaPkg::*;

	localparam int X_BITS = $clog2(WIDTH);
	localparam int Y_BITS = $clog2(HEIGHT);

	// Tile size in pixels
	localparam int TILE_W = WIDTH / TILE_COLUMNS;
	localparam int TILE_H = HEIGHT / TILE_ROWS;

	// Index widths for the grid
	localparam int COL_BITS = $clog2(TILE_COLUMNS);
	localparam int ROW_BITS = $clog2(TILE_ROWS);
	localparam int TILE_BITS = $clog2(TILE_COLUMNS * TILE_ROWS);

	logic [COL_BITS-1:0] tileCol;
	logic [ROW_BITS-1:0] tileRow;
	logic [TILE_BITS-1:0] tileNum;

	// First stage result, then one more stage to meet the palette read
	color_t stageColor;

	// Column is the number of tile boundaries already passed
	// Leftover pixels of an uneven split fall into the last column
	always_comb begin
		tileCol = '0;
		for (int c = 1; c < TILE_COLUMNS; c++) begin
			if (x >= X_BITS'(c * TILE_W)) begin
				tileCol = COL_BITS'(c);
			end
		end
	end

	// Same for the row
	always_comb begin
		tileRow = '0;
		for (int r = 1; r < TILE_ROWS; r++) begin
			if (y >= Y_BITS'(r * TILE_H)) begin
				tileRow = ROW_BITS'(r);
			end
		end
	end

	// Tile number, row major
	assign tileNum = TILE_BITS'(tileRow) * TILE_BITS'(TILE_COLUMNS) + TILE_BITS'(tileCol);

	// Score sampled here, tile k goes black once the score passes k
	always_ff @(posedge clk) begin
		if (score > score_t'(tileNum)) begin
			stageColor <= COLOR_BLACK;
		end else begin
			stageColor <= COLOR_WHITE;
		end
	end

	// Second stage, lines up with the palette output
	always_ff @(posedge clk) begin
		tileColor <= stageColor;
	end

endmodule

`default_nettype wire

//--- hw/syncRam.sv
`default_nettype none

module syncRam #(
	parameter int DEPTH = 256,
	parameter int DATA_WIDTH = 12
) (
	input wire logic clk,
	input wire logic writeEn,
	input wire logic [$clog2(DEPTH)-1:0] writeAddr,
	input wire logic [DATA_WIDTH-1:0] writeData,
	input wire logic [$clog2(DEPTH)-1:0] readAddr,
	output logic [DATA_WIDTH-1:0] readData
);

	// Storage array, maps to block RAM
	logic [DATA_WIDTH-1:0] mem [DEPTH];

	// Write port
	always_ff @(posedge clk) begin
		if (writeEn) begin
			mem[writeAddr] <= writeData;
		end
	end

	// Registered read, one cycle of latency
	// Same address written in the same cycle reads the old contents
	always_ff @(posedge clk) begin
		readData <= mem[readAddr];
	end

endmodule

`default_nettype wire

//--- hw/vgaController.sv
`default_nettype none

module vgaController #(
	parameter int WIDTH = 640,
	parameter int HEIGHT = 480,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic ingame,
	input wire vgaPkg::score_t score,
	input wire logic imgWrite,
	input wire logic [$clog2(WIDTH*HEIGHT)-1:0] imgWriteAddr,
	input wire vgaPkg::paletteIndex_t imgWriteIndex,
	input wire logic palWrite,
	input wire vgaPkg::paletteIndex_t palWriteAddr,
	input wire vgaPkg::color_t palWriteColor,
	output logic hSync,
	output logic vSync,
	output logic [vgaPkg::CHANNEL_BITS-1:0] vgaR,
	output logic [vgaPkg::CHANNEL_BITS-1:0] vgaG,
	output logic [vgaPkg::CHANNEL_BITS-1:0] vgaB
);

	import vgaPkg::*;

	localparam int PIXEL_COUNT = WIDTH * HEIGHT;
	localparam int ADDR_BITS = $clog2(PIXEL_COUNT);
	localparam int X_BITS = $clog2(WIDTH);
	localparam int Y_BITS = $clog2(HEIGHT);

	// Raster position from the timing generator
	logic [X_BITS-1:0] x;
	logic [Y_BITS-1:0] y;
	logic [ADDR_BITS-1:0] pixelAddr;
	logic active;
	logic hSyncRaw;
	logic vSyncRaw;

	// Attract screen lookup chain
	paletteIndex_t pixelIndex;
	color_t imageColor;

	// Score board color, same latency as imageColor
	color_t tileColor;

	// Counters, syncs and linear address
	vgaTiming #(
		.WIDTH(WIDTH),
		.HEIGHT(HEIGHT),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) timingGen (
		.clk(clk),
		.reset(reset),
		.x(x),
		.y(y),
		.pixelAddr(pixelAddr),
		.active(active),
		.hSyncRaw(hSyncRaw),
		.vSyncRaw(vSyncRaw)
	);

	// Image memory, one palette index per pixel
	syncRam #(
		.DEPTH(PIXEL_COUNT),
		.DATA_WIDTH($bits(paletteIndex_t))
	) imageRam (
		.clk(clk),
		.writeEn(imgWrite),
		.writeAddr(imgWriteAddr),
		.writeData(imgWriteIndex),
		.readAddr(pixelAddr),
		.readData(pixelIndex)
	);

	// Palette, index to 12-bit color
	syncRam #(
		.DEPTH(PALETTE_DEPTH),
		.DATA_WIDTH($bits(color_t))
	) paletteRam (
		.clk(clk),
		.writeEn(palWrite),
		.writeAddr(palWriteAddr),
		.writeData(palWriteColor),
		.readAddr(pixelIndex),
		.readData(imageColor)
	);

	// In-game score board
	scoreTiles #(
		.WIDTH(WIDTH),
		.HEIGHT(HEIGHT)
	) tiles (
		.clk(clk),
		.x(x),
		.y(y),
		.score(score),
		.tileColor(tileColor)
	);

	// Picture select, blanking and output registers
	pixelOutput outStage (
		.clk(clk),
		.reset(reset),
		.active(active),
		.hSyncRaw(hSyncRaw),
		.vSyncRaw(vSyncRaw),
		.imageColor(imageColor),
		.tileColor(tileColor),
		.ingame(ingame),
		.hSync(hSync),
		.vSync(vSync),
		.vgaR(vgaR),
		.vgaG(vgaG),
		.vgaB(vgaB)
	);

endmodule

`default_nettype wire

//--- hw/vgaPkg.sv
`default_nettype none

package vgaPkg;

	// Bits per color channel on the DAC pins
	localparam int CHANNEL_BITS = 4;

	// 12-bit color, red in the top nibble, then green, then blue
	typedef logic [3*CHANNEL_BITS-1:0] color_t;

	// Palette index stored per pixel in the image memory
	typedef logic [7:0] paletteIndex_t;

	// Score level from the game logic, compared unsigned
	typedef logic [31:0] score_t;

	// Number of palette entries, one per possible index
	localparam int PALETTE_DEPTH = 256;

	// Score board grid
	// Tile number is row * TILE_COLUMNS + column
	localparam int TILE_COLUMNS = 4;
	localparam int TILE_ROWS = 3;

	// Tile colors
	localparam color_t COLOR_BLACK = '0;
	localparam color_t COLOR_WHITE = '1;

endpackage

`default_nettype wire

//--- hw/vgaTiming.sv
`default_nettype none

module vgaTiming #(
	parameter int WIDTH = 640,
	parameter int HEIGHT = 480,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
) (
	input wire logic clk,
	input wire logic reset,
	output logic [$clog2(WIDTH)-1:0] x,
	output logic [$clog2(HEIGHT)-1:0] y,
	output logic [$clog2(WIDTH*HEIGHT)-1:0] pixelAddr,
	output logic active,
	output logic hSyncRaw,
	output logic vSyncRaw
);

	// Full line and frame lengths including porches and sync
	localparam int H_TOTAL = WIDTH + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = HEIGHT + V_FRONT + V_SYNC + V_BACK;
	localparam int H_BITS = $clog2(H_TOTAL);
	localparam int V_BITS = $clog2(V_TOTAL);
	localparam int X_BITS = $clog2(WIDTH);
	localparam int Y_BITS = $clog2(HEIGHT);
	localparam int PIXEL_COUNT = WIDTH * HEIGHT;
	localparam int ADDR_BITS = $clog2(PIXEL_COUNT);

	// Sync pulse sits after the front porch
	localparam int H_SYNC_START = WIDTH + H_FRONT;
	localparam int H_SYNC_END = H_SYNC_START + H_SYNC;
	localparam int V_SYNC_START = HEIGHT + V_FRONT;
	localparam int V_SYNC_END = V_SYNC_START + V_SYNC;

	// Position in the line and line in the frame
	logic [H_BITS-1:0] hCount;
	logic [V_BITS-1:0] vCount;
	logic lineEnd;
	logic frameEnd;

	assign lineEnd = (hCount == H_BITS'(H_TOTAL - 1));
	assign frameEnd = (vCount == V_BITS'(V_TOTAL - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			hCount <= '0;
			vCount <= '0;
		end else begin
			// Wrap the pixel counter at the end of each line
			if (lineEnd) begin
				hCount <= '0;
				// Line counter moves once per line
				if (frameEnd) begin
					vCount <= '0;
				end else begin
					vCount <= vCount + 1'b1;
				end
			end else begin
				hCount <= hCount + 1'b1;
			end
		end
	end

	// Linear address of the current active pixel
	// Steps only on visible pixels, so it equals y * WIDTH + x without a multiplier
	always_ff @(posedge clk) begin
		if (reset) begin
			pixelAddr <= '0;
		end else if (active) begin
			// Last visible pixel of the frame, back to the top left corner
			if (pixelAddr == ADDR_BITS'(PIXEL_COUNT - 1)) begin
				pixelAddr <= '0;
			end else begin
				pixelAddr <= pixelAddr + 1'b1;
			end
		end
	end

	// Visible area
	assign active = (hCount < H_BITS'(WIDTH)) && (vCount < V_BITS'(HEIGHT));

	// Coordinates only carry meaning while active is high
	assign x = hCount[X_BITS-1:0];
	assign y = vCount[Y_BITS-1:0];

	// Both syncs are active low
	assign hSyncRaw = !((hCount >= H_BITS'(H_SYNC_START)) && (hCount < H_BITS'(H_SYNC_END)));
	assign vSyncRaw = !((vCount >= V_BITS'(V_SYNC_START)) && (vCount < V_BITS'(V_SYNC_END)));

endmodule

`default_nettype wire

//--- tb/vgaControllerTb.sv
`default_nettype none

module vgaControllerTb;

	timeunit 1ns;
	timeprecision 100ps;

	import vgaPkg::*;

	// Small geometry so a frame is short
	localparam int WIDTH = 32;
	localparam int HEIGHT = 24;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 4;
	localparam int H_BACK = 2;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 1;

	localparam int H_TOTAL = WIDTH + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = HEIGHT + V_FRONT + V_SYNC + V_BACK;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int PIXEL_COUNT = WIDTH * HEIGHT;
	localparam int ADDR_BITS = $clog2(PIXEL_COUNT);
	localparam int H_SYNC_START = WIDTH + H_FRONT;
	localparam int V_SYNC_START = HEIGHT + V_FRONT;
	localparam int TILE_W = WIDTH / TILE_COLUMNS;
	localparam int TILE_H = HEIGHT / TILE_ROWS;

	// Timing cycle t reaches the pins at t+3
	localparam int PIPE_LATENCY = 3;

	// Line inside vertical blanking where inputs may change
	localparam int MARK_LINE = HEIGHT + 1;

	// About 8 checked frames plus the memory load, with margin
	localparam int TIMEOUT_CYCLES = 12 * FRAME_CYCLES + 1500;
	localparam logic [31:0] SEED = 32'hc8ebf8e5;

	logic clk;
	logic reset;
	logic ingame;
	score_t score;
	logic imgWrite;
	logic [ADDR_BITS-1:0] imgWriteAddr;
	paletteIndex_t imgWriteIndex;
	logic palWrite;
	paletteIndex_t palWriteAddr;
	color_t palWriteColor;
	logic hSync;
	logic vSync;
	logic [3:0] vgaR;
	logic [3:0] vgaG;
	logic [3:0] vgaB;

	// Model copies of both memories, updated as each write is driven
	paletteIndex_t imgModel [PIXEL_COUNT];
	color_t palModel [PALETTE_DEPTH];

	// Timing cycle index, 0 in the first cycle after reset release
	int relCycle = 0;
	int cycleCounter = 0;
	int errorCount = 0;
	int checkCount = 0;
	int passCount = 0;
	int failCount = 0;
	logic colorCheckOn = 1'b0;

	vgaController #(
		.WIDTH(WIDTH),
		.HEIGHT(HEIGHT),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.ingame(ingame),
		.score(score),
		.imgWrite(imgWrite),
		.imgWriteAddr(imgWriteAddr),
		.imgWriteIndex(imgWriteIndex),
		.palWrite(palWrite),
		.palWriteAddr(palWriteAddr),
		.palWriteColor(palWriteColor),
		.hSync(hSync),
		.vSync(vSync),
		.vgaR(vgaR),
		.vgaG(vgaG),
		.vgaB(vgaB)
	);

	// 40 ns clock
	initial clk = 1'b0;
	always #20 clk = !clk;

	function automatic int pixelOf(input int t);
		return t % H_TOTAL;
	endfunction

	function automatic int lineOf(input int t);
		return (t / H_TOTAL) % V_TOTAL;
	endfunction

	// Expected pixel color from raster position, game state and model memories
	function automatic color_t expectedColor(input int h, input int v, input logic game,
			input score_t s);
		int tileNum;
		color_t result;
		if (h >= WIDTH || v >= HEIGHT) begin
			result = 12'h000;
		end else if (game) begin
			// Row major tile number, black once the score passes it
			tileNum = (v / TILE_H) * TILE_COLUMNS + h / TILE_W;
			result = (s > score_t'(tileNum)) ? 12'h000 : 12'hfff;
		end else begin
			result = palModel[imgModel[v * WIDTH + h]];
		end
		return result;
	endfunction

	// Raster tracker, restarts while reset is seen
	always @(posedge clk) begin
		if (reset) begin
			relCycle <= 0;
		end else begin
			relCycle <= relCycle + 1;
		end
	end

	// Run limit
	always @(posedge clk) begin
		cycleCounter <= cycleCounter + 1;
		if (cycleCounter >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// Compare on the falling edge, outputs are settled there
	always @(negedge clk) begin : compareOutputs
		int t;
		int h;
		int v;
		logic expH;
		logic expV;
		logic colorDue;
		color_t expColor;
		color_t gotColor;
		if (!reset) begin
			gotColor = {vgaR, vgaG, vgaB};
			h = 0;
			v = 0;
			if (relCycle < PIPE_LATENCY) begin
				// Pipeline still filling from reset
				expH = 1'b1;
				expV = 1'b1;
				expColor = 12'h000;
				colorDue = 1'b1;
			end else begin
				t = relCycle - PIPE_LATENCY;
				h = pixelOf(t);
				v = lineOf(t);
				expH = !(h >= H_SYNC_START && h < H_SYNC_START + H_SYNC);
				expV = !(v >= V_SYNC_START && v < V_SYNC_START + V_SYNC);
				// ingame and score only move in vertical blanking, so current levels apply
				expColor = expectedColor(h, v, ingame, score);
				colorDue = colorCheckOn || h >= WIDTH || v >= HEIGHT;
			end
			checkCount++;
			if (hSync !== expH) begin
				errorCount++;
				$display("Error at %0t: hSync is %b, expected %b (line %0d pixel %0d)",
					$time, hSync, expH, v, h);
			end
			if (vSync !== expV) begin
				errorCount++;
				$display("Error at %0t: vSync is %b, expected %b (line %0d pixel %0d)",
					$time, vSync, expV, v, h);
			end
			if (colorDue && gotColor !== expColor) begin
				errorCount++;
				$display("Error at %0t: color is %h, expected %h (line %0d pixel %0d)",
					$time, gotColor, expColor, v, h);
			end
		end
	end

	// Both strobes are driven on every write so only one is ever high
	task automatic writeImage(input int addr, input int index);
		@(posedge clk);
		imgWrite <= 1'b1;
		imgWriteAddr <= ADDR_BITS'(addr);
		imgWriteIndex <= paletteIndex_t'(index);
		palWrite <= 1'b0;
		imgModel[addr] = paletteIndex_t'(index);
	endtask

	task automatic writePalette(input int index, input color_t color);
		@(posedge clk);
		palWrite <= 1'b1;
		palWriteAddr <= paletteIndex_t'(index);
		palWriteColor <= color;
		imgWrite <= 1'b0;
		palModel[index] = color;
	endtask

	task automatic stopWrites();
		@(posedge clk);
		imgWrite <= 1'b0;
		palWrite <= 1'b0;
	endtask

	// Returns at the edge that starts the mark cycle in vertical blanking
	// relCycle still holds the cycle that just ended, hence the + 1
	task automatic waitFrameMark();
		do begin
			@(posedge clk);
		end while (!(lineOf(relCycle + 1) == MARK_LINE && pixelOf(relCycle + 1) == 0));
	endtask

	task automatic finishTest(input string name, input int startErrors);
		if (errorCount == startErrors) begin
			passCount++;
			$display("Test %s: passed", name);
		end else begin
			failCount++;
			$display("Test %s: failed with %0d errors", name, errorCount - startErrors);
		end
	endtask

	initial begin : stimulus
		int seedValue;
		int startErrors;
		int index;
		color_t newColor;
		score_t scoreList [5];
		seedValue = $urandom(SEED);
		reset = 1'b1;
		ingame = 1'b0;
		score = '0;
		imgWrite = 1'b0;
		imgWriteAddr = '0;
		imgWriteIndex = '0;
		palWrite = 1'b0;
		palWriteAddr = '0;
		palWriteColor = '0;
		scoreList[0] = 0;
		scoreList[1] = 5;
		scoreList[2] = 11;
		scoreList[3] = 12;
		scoreList[4] = $urandom | 32'h8000_0000;

		// Two cycles of reset, then the pipeline fill
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		startErrors = errorCount;
		repeat (PIPE_LATENCY) @(posedge clk);
		finishTest("after reset", startErrors);

		// Random image and palette, syncs and blanking checked meanwhile
		startErrors = errorCount;
		for (int a = 0; a < PIXEL_COUNT; a++) begin
			writeImage(a, $urandom & 8'hff);
		end
		for (int p = 0; p < PALETTE_DEPTH; p++) begin
			writePalette(p, color_t'($urandom & 12'hfff));
		end
		stopWrites();
		waitFrameMark();
		colorCheckOn = 1'b1;
		finishTest("raster timing", startErrors);

		// One full attract frame
		startErrors = errorCount;
		waitFrameMark();
		finishTest("attract screen", startErrors);

		// Score board, one frame per score
		for (int i = 0; i < 5; i++) begin
			ingame <= 1'b1;
			score <= scoreList[i];
			startErrors = errorCount;
			waitFrameMark();
			finishTest($sformatf("score board with score %0d", scoreList[i]), startErrors);
		end

		// Rewrite one palette entry that the image really uses
		ingame <= 1'b0;
		index = imgModel[$urandom % PIXEL_COUNT];
		newColor = palModel[index] ^ 12'h5a5;
		startErrors = errorCount;
		writePalette(index, newColor);
		stopWrites();
		waitFrameMark();
		finishTest($sformatf("palette rewrite of index %0d", index), startErrors);

		$display("Tests passed: %0d, failed: %0d, checks: %0d, errors: %0d",
			passCount, failCount, checkCount, errorCount);
		if (failCount == 0 && errorCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
hw/vgaPkg.sv
hw/vgaTiming.sv
hw/syncRam.sv
hw/scoreTiles.sv
hw/pixelOutput.sv
hw/vgaController.sv
tb/vgaControllerTb.sv
